/* common/vi_pkg.sv */
// Shared widths and encodings; only the RV32I ALU, OP-IMM and BEQ/BNE subset is encoded here
package vi_pkg;

	localparam int XLEN       = 32;
	localparam int PADDR_W    = 20;
	localparam int LINE_W     = 128;
	localparam int REG_ADDR_W = 5;

	// Major opcodes, RISC-V encoding
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_BRANCH = 7'b1100011
	} opcode_e;

	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		AND = 4'd2,
		OR  = 4'd3,
		XOR = 4'd4,
		SLT = 4'd5,
		SLL = 4'd6,
		SRL = 4'd7,
		BEQ = 4'd8,
		BNE = 4'd9
	} alu_op_e;

	// Fetch sequencing
	typedef enum logic {
		F_REQ  = 1'b0,
		F_WAIT = 1'b1
	} fetch_state_e;

endpackage

/* source/vi_mem_delay.sv */
// Fixed latency of MEM_DELAY cycles each way, MEM_DELAY must be 2 or more; no back-pressure
`timescale 1ns/1ns

module vi_mem_delay import vi_pkg::*; #(
	parameter int MEM_DELAY = 4
) (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               req_i,
	input  logic [PADDR_W-1:0] req_addr_i,
	output logic               mem_read_o,
	output logic [PADDR_W-1:0] mem_read_addr_o,
	input  logic               mem_data_ready_i,
	input  logic [LINE_W-1:0]  mem_data_i,
	input  logic [PADDR_W-1:0] mem_addr_i,
	output logic               rsp_valid_o,
	output logic [LINE_W-1:0]  rsp_data_o,
	output logic [PADDR_W-1:0] rsp_addr_o
);

	logic [MEM_DELAY-1:0] req_q;
	logic [PADDR_W-1:0]   req_addr_q [MEM_DELAY];
	logic [MEM_DELAY-1:0] rsp_q;
	logic [LINE_W-1:0]    rsp_data_q [MEM_DELAY];
	logic [PADDR_W-1:0]   rsp_addr_q [MEM_DELAY];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			req_q <= '0;
			rsp_q <= '0;
			for (int i = 0; i < MEM_DELAY; i++) begin
				req_addr_q[i] <= '0;
				rsp_data_q[i] <= '0;
				rsp_addr_q[i] <= '0;
			end
		end else begin
			req_q <= {req_q[MEM_DELAY-2:0], req_i};
			rsp_q <= {rsp_q[MEM_DELAY-2:0], mem_data_ready_i};
			req_addr_q[0] <= req_addr_i;
			rsp_data_q[0] <= mem_data_i;
			rsp_addr_q[0] <= mem_addr_i;
			for (int i = 1; i < MEM_DELAY; i++) begin
				req_addr_q[i] <= req_addr_q[i-1];
				rsp_data_q[i] <= rsp_data_q[i-1];
				rsp_addr_q[i] <= rsp_addr_q[i-1];
			end
		end
	end

	// Oldest stage faces memory outward and fetch inward
	assign mem_read_o      = req_q[MEM_DELAY-1];
	assign mem_read_addr_o = req_addr_q[MEM_DELAY-1];
	assign rsp_valid_o     = rsp_q[MEM_DELAY-1];
	assign rsp_data_o      = rsp_data_q[MEM_DELAY-1];
	assign rsp_addr_o      = rsp_addr_q[MEM_DELAY-1];

	// A stale response must not reach fetch across a reset
	a_no_rsp_in_reset: assert property (
		@(posedge clk_i) reset_i |=> !rsp_valid_o
	);

endmodule

/* fetch/vi_fetch.sv */
// One line in flight at a time; responses for other line addresses are ignored
`timescale 1ns/1ns

module vi_fetch import vi_pkg::*; #(
	parameter logic [XLEN-1:0] BOOT_PC = '0
) (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               rsp_valid_i,
	input  logic [LINE_W-1:0]  rsp_data_i,
	input  logic [PADDR_W-1:0] rsp_addr_i,
	input  logic               redirect_i,
	input  logic [XLEN-1:0]    redirect_pc_i,
	output logic               req_o,
	output logic [PADDR_W-1:0] req_addr_o,
	output logic               if_valid_o,
	output logic [XLEN-1:0]    if_instr_o,
	output logic [XLEN-1:0]    if_pc_o
);

	fetch_state_e       state_q;
	logic [XLEN-1:0]    pc_q;
	logic [PADDR_W-1:0] line_addr_q;
	logic [LINE_W-1:0]  line_q;
	logic               line_valid_q;
	logic               cancel_q;
	logic               rsp_hit;
	logic               last_word;

	// A redirect holds back the request so the target goes out next cycle
	assign req_o      = (state_q == F_REQ) && !redirect_i;
	assign req_addr_o = {pc_q[PADDR_W-1:4], 4'b0000};
	assign rsp_hit    = rsp_valid_i && (rsp_addr_i == line_addr_q);
	assign last_word  = (pc_q[3:2] == 2'b11);

	assign if_valid_o = line_valid_q;
	assign if_instr_o = line_q[pc_q[3:2]*XLEN +: XLEN];
	assign if_pc_o    = pc_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q      <= F_REQ;
			pc_q         <= BOOT_PC;
			line_valid_q <= 1'b0;
			cancel_q     <= 1'b0;
		end else begin
			if (redirect_i)
				pc_q <= redirect_pc_i;
			else if (line_valid_q)
				pc_q <= pc_q + XLEN'(4);

			case (state_q)
				F_REQ: begin
					if (req_o)
						state_q <= F_WAIT;
				end
				F_WAIT: begin
					if (line_valid_q) begin
						if (redirect_i || last_word) begin
							line_valid_q <= 1'b0;
							state_q      <= F_REQ;
						end
					end else if (rsp_hit && (cancel_q || redirect_i)) begin
						// Wrong-path line arrived, drop it and refetch
						cancel_q <= 1'b0;
						state_q  <= F_REQ;
					end else if (rsp_hit) begin
						line_valid_q <= 1'b1;
					end else if (redirect_i) begin
						cancel_q <= 1'b1;
					end
				end
				default: state_q <= F_REQ;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_o)
			line_addr_q <= req_addr_o;
		if (state_q == F_WAIT && !line_valid_q && !cancel_q && rsp_hit)
			line_q <= rsp_data_i;
	end

	a_no_req_in_wait: assert property (
		@(posedge clk_i) disable iff (reset_i) (state_q == F_WAIT) |-> !req_o
	);

endmodule

/* decode/vi_int_registers.sv */
// Combinational read, write at the clock edge; a same-cycle write is not seen by the read
`timescale 1ns/1ns

module vi_int_registers import vi_pkg::*; (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic [REG_ADDR_W-1:0] rs1_addr_i,
	input  logic [REG_ADDR_W-1:0] rs2_addr_i,
	output logic [XLEN-1:0]       rs1_data_o,
	output logic [XLEN-1:0]       rs2_data_o,
	input  logic                  wr_en_i,
	input  logic [REG_ADDR_W-1:0] wr_addr_i,
	input  logic [XLEN-1:0]       wr_data_i
);

	localparam int NUM_REGS = 1 << REG_ADDR_W;

	logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 1; i < NUM_REGS; i++)
				regs_q[i] <= '0;
		end else if (wr_en_i && wr_addr_i != '0) begin
			regs_q[wr_addr_i] <= wr_data_i;
		end
	end

	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

	// Decode already clears the enable for x0, so writeback never targets it
	a_no_x0_write: assert property (
		@(posedge clk_i) disable iff (reset_i) wr_en_i |-> (wr_addr_i != '0)
	);

endmodule

/* decode/vi_bypass_ctrl.sv */
// Execute result wins over writeback; enables must already be qualified by valid
`timescale 1ns/1ns

module vi_bypass_ctrl import vi_pkg::*; (
	input  logic [REG_ADDR_W-1:0] rs1_addr_i,
	input  logic [REG_ADDR_W-1:0] rs2_addr_i,
	input  logic [XLEN-1:0]       rf_a_i,
	input  logic [XLEN-1:0]       rf_b_i,
	input  logic                  ex_wen_i,
	input  logic [REG_ADDR_W-1:0] ex_rd_i,
	input  logic [XLEN-1:0]       ex_result_i,
	input  logic                  wb_wen_i,
	input  logic [REG_ADDR_W-1:0] wb_rd_i,
	input  logic [XLEN-1:0]       wb_data_i,
	output logic [XLEN-1:0]       op_a_o,
	output logic [XLEN-1:0]       op_b_o
);

	function automatic logic [XLEN-1:0] select_operand(
		input logic [REG_ADDR_W-1:0] src,
		input logic [XLEN-1:0]       rf_data
	);
		logic [XLEN-1:0] result;
		result = rf_data;
		if (src != '0) begin
			if (ex_wen_i && ex_rd_i == src)
				result = ex_result_i;
			else if (wb_wen_i && wb_rd_i == src)
				result = wb_data_i;
		end
		return result;
	endfunction

	assign op_a_o = select_operand(rs1_addr_i, rf_a_i);
	assign op_b_o = select_operand(rs2_addr_i, rf_b_i);

endmodule

/* decode/vi_decoder.sv */
// Decodes OP, OP-IMM, BEQ and BNE only; everything else, SRA and SLTU included, is a bubble
`timescale 1ns/1ns

module vi_decoder import vi_pkg::*; (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  if_valid_i,
	input  logic [XLEN-1:0]       if_instr_i,
	input  logic [XLEN-1:0]       if_pc_i,
	input  logic                  kill_i,
	output logic [REG_ADDR_W-1:0] rs1_addr_o,
	output logic [REG_ADDR_W-1:0] rs2_addr_o,
	input  logic [XLEN-1:0]       op_a_i,
	input  logic [XLEN-1:0]       op_b_i,
	output logic                  ex_valid_o,
	output alu_op_e               ex_op_o,
	output logic                  ex_is_branch_o,
	output logic [XLEN-1:0]       ex_a_o,
	output logic [XLEN-1:0]       ex_b_o,
	output logic [XLEN-1:0]       ex_imm_o,
	output logic [XLEN-1:0]       ex_pc_o,
	output logic [REG_ADDR_W-1:0] ex_rd_o,
	output logic                  ex_wen_o
);

	opcode_e               opcode;
	logic [2:0]            funct3;
	logic [REG_ADDR_W-1:0] rd;
	logic [XLEN-1:0]       imm_i;
	logic [XLEN-1:0]       imm_b;
	logic [XLEN-1:0]       dec_b;
	alu_op_e               dec_op;
	logic                  dec_ok;
	logic                  dec_branch;
	logic                  dec_wen;

	assign opcode     = opcode_e'(if_instr_i[6:0]);
	assign rd         = if_instr_i[11:7];
	assign funct3     = if_instr_i[14:12];
	assign rs1_addr_o = if_instr_i[19:15];
	assign rs2_addr_o = if_instr_i[24:20];

	assign imm_i = {{(XLEN-12){if_instr_i[31]}}, if_instr_i[31:20]};
	assign imm_b = {{(XLEN-12){if_instr_i[31]}}, if_instr_i[7], if_instr_i[30:25],
		if_instr_i[11:8], 1'b0};

	always_comb begin
		dec_ok     = 1'b0;
		dec_branch = 1'b0;
		dec_wen    = (rd != '0);
		dec_op     = ADD;
		dec_b      = op_b_i;
		case (opcode)
			OPC_OP, OPC_OP_IMM: begin
				dec_ok = 1'b1;
				if (opcode == OPC_OP_IMM)
					dec_b = imm_i;
				case (funct3)
					3'b000: dec_op = (opcode == OPC_OP && if_instr_i[30]) ? SUB : ADD;
					3'b001: dec_op = SLL;
					3'b010: dec_op = SLT;
					3'b100: dec_op = XOR;
					3'b101: begin
						// Arithmetic shift is not supported
						dec_op = SRL;
						dec_ok = !if_instr_i[30];
					end
					3'b110: dec_op = OR;
					3'b111: dec_op = AND;
					default: dec_ok = 1'b0;
				endcase
			end
			OPC_BRANCH: begin
				dec_branch = 1'b1;
				dec_wen    = 1'b0;
				dec_ok     = (funct3 == 3'b000) || (funct3 == 3'b001);
				dec_op     = funct3[0] ? BNE : BEQ;
			end
			default: dec_ok = 1'b0;
		endcase
	end

	// Kill drops the word decoded in the redirect cycle
	always_ff @(posedge clk_i) begin
		if (reset_i || kill_i) begin
			ex_valid_o     <= 1'b0;
			ex_wen_o       <= 1'b0;
			ex_is_branch_o <= 1'b0;
		end else begin
			ex_valid_o     <= if_valid_i && dec_ok;
			ex_wen_o       <= if_valid_i && dec_ok && dec_wen;
			ex_is_branch_o <= if_valid_i && dec_ok && dec_branch;
		end
	end

	always_ff @(posedge clk_i) begin
		ex_op_o  <= dec_op;
		ex_a_o   <= op_a_i;
		ex_b_o   <= dec_b;
		ex_imm_o <= imm_b;
		ex_pc_o  <= if_pc_i;
		ex_rd_o  <= rd;
	end

endmodule

/* execute/vi_int_alu.sv */
// Single-cycle ALU; redirect is combinational and a taken branch retires nothing
`timescale 1ns/1ns

module vi_int_alu import vi_pkg::*; (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  ex_valid_i,
	input  alu_op_e               ex_op_i,
	input  logic                  ex_is_branch_i,
	input  logic [XLEN-1:0]       ex_a_i,
	input  logic [XLEN-1:0]       ex_b_i,
	input  logic [XLEN-1:0]       ex_imm_i,
	input  logic [XLEN-1:0]       ex_pc_i,
	input  logic [REG_ADDR_W-1:0] ex_rd_i,
	input  logic                  ex_wen_i,
	output logic [XLEN-1:0]       ex_result_o,
	output logic                  redirect_o,
	output logic [XLEN-1:0]       redirect_pc_o,
	output logic                  wb_valid_o,
	output logic [REG_ADDR_W-1:0] wb_rd_o,
	output logic [XLEN-1:0]       wb_data_o
);

	localparam int SHAMT_W = $clog2(XLEN);

	logic equal;
	logic less;

	assign equal = (ex_a_i == ex_b_i);
	assign less  = ($signed(ex_a_i) < $signed(ex_b_i));

	always_comb begin
		case (ex_op_i)
			ADD:     ex_result_o = ex_a_i + ex_b_i;
			SUB:     ex_result_o = ex_a_i - ex_b_i;
			AND:     ex_result_o = ex_a_i & ex_b_i;
			OR:      ex_result_o = ex_a_i | ex_b_i;
			XOR:     ex_result_o = ex_a_i ^ ex_b_i;
			SLT:     ex_result_o = {{(XLEN-1){1'b0}}, less};
			SLL:     ex_result_o = ex_a_i << ex_b_i[SHAMT_W-1:0];
			SRL:     ex_result_o = ex_a_i >> ex_b_i[SHAMT_W-1:0];
			default: ex_result_o = '0;
		endcase
	end

	// Only forward branches and self-branches are expected, target is PC plus offset
	assign redirect_o    = ex_valid_i && ex_is_branch_i && ((ex_op_i == BNE) ? !equal : equal);
	assign redirect_pc_o = ex_pc_i + ex_imm_i;

	always_ff @(posedge clk_i) begin
		if (reset_i)
			wb_valid_o <= 1'b0;
		else
			wb_valid_o <= ex_valid_i && ex_wen_i;
	end

	always_ff @(posedge clk_i) begin
		wb_rd_o   <= ex_rd_i;
		wb_data_o <= ex_result_o;
	end

endmodule

/* source/vi_core.sv */
// In-order core without caches, loads or stores; memory must answer every read, never stalls
`timescale 1ns/1ns

module vi_core import vi_pkg::*; #(
	parameter int              MEM_DELAY = 4,
	parameter logic [XLEN-1:0] BOOT_PC   = '0
) (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  mem_data_ready_i,
	input  logic [LINE_W-1:0]     mem_data_i,
	input  logic [PADDR_W-1:0]    mem_addr_i,
	output logic                  mem_read_o,
	output logic [PADDR_W-1:0]    mem_read_addr_o,
	output logic                  retire_valid_o,
	output logic [REG_ADDR_W-1:0] retire_addr_o,
	output logic [XLEN-1:0]       retire_data_o
);

	logic                  req;
	logic [PADDR_W-1:0]    req_addr;
	logic                  rsp_valid;
	logic [LINE_W-1:0]     rsp_data;
	logic [PADDR_W-1:0]    rsp_addr;
	logic                  redirect;
	logic [XLEN-1:0]       redirect_pc;
	logic                  if_valid;
	logic [XLEN-1:0]       if_instr;
	logic [XLEN-1:0]       if_pc;
	logic [REG_ADDR_W-1:0] rs1_addr;
	logic [REG_ADDR_W-1:0] rs2_addr;
	logic [XLEN-1:0]       rf_a;
	logic [XLEN-1:0]       rf_b;
	logic [XLEN-1:0]       op_a;
	logic [XLEN-1:0]       op_b;
	logic                  ex_valid;
	alu_op_e               ex_op;
	logic                  ex_is_branch;
	logic [XLEN-1:0]       ex_a;
	logic [XLEN-1:0]       ex_b;
	logic [XLEN-1:0]       ex_imm;
	logic [XLEN-1:0]       ex_pc;
	logic [REG_ADDR_W-1:0] ex_rd;
	logic                  ex_wen;
	logic [XLEN-1:0]       ex_result;
	logic                  wb_valid;
	logic [REG_ADDR_W-1:0] wb_rd;
	logic [XLEN-1:0]       wb_data;

	vi_mem_delay #(.MEM_DELAY(MEM_DELAY)) u_mem_delay (
		.clk_i            (clk_i),
		.reset_i          (reset_i),
		.req_i            (req),
		.req_addr_i       (req_addr),
		.mem_read_o       (mem_read_o),
		.mem_read_addr_o  (mem_read_addr_o),
		.mem_data_ready_i (mem_data_ready_i),
		.mem_data_i       (mem_data_i),
		.mem_addr_i       (mem_addr_i),
		.rsp_valid_o      (rsp_valid),
		.rsp_data_o       (rsp_data),
		.rsp_addr_o       (rsp_addr)
	);

	vi_fetch #(.BOOT_PC(BOOT_PC)) u_fetch (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.rsp_valid_i   (rsp_valid),
		.rsp_data_i    (rsp_data),
		.rsp_addr_i    (rsp_addr),
		.redirect_i    (redirect),
		.redirect_pc_i (redirect_pc),
		.req_o         (req),
		.req_addr_o    (req_addr),
		.if_valid_o    (if_valid),
		.if_instr_o    (if_instr),
		.if_pc_o       (if_pc)
	);

	vi_decoder u_decoder (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.if_valid_i     (if_valid),
		.if_instr_i     (if_instr),
		.if_pc_i        (if_pc),
		.kill_i         (redirect),
		.rs1_addr_o     (rs1_addr),
		.rs2_addr_o     (rs2_addr),
		.op_a_i         (op_a),
		.op_b_i         (op_b),
		.ex_valid_o     (ex_valid),
		.ex_op_o        (ex_op),
		.ex_is_branch_o (ex_is_branch),
		.ex_a_o         (ex_a),
		.ex_b_o         (ex_b),
		.ex_imm_o       (ex_imm),
		.ex_pc_o        (ex_pc),
		.ex_rd_o        (ex_rd),
		.ex_wen_o       (ex_wen)
	);

	vi_int_registers u_int_registers (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_data_o (rf_a),
		.rs2_data_o (rf_b),
		.wr_en_i    (wb_valid),
		.wr_addr_i  (wb_rd),
		.wr_data_i  (wb_data)
	);

	vi_bypass_ctrl u_bypass_ctrl (
		.rs1_addr_i  (rs1_addr),
		.rs2_addr_i  (rs2_addr),
		.rf_a_i      (rf_a),
		.rf_b_i      (rf_b),
		.ex_wen_i    (ex_wen),
		.ex_rd_i     (ex_rd),
		.ex_result_i (ex_result),
		.wb_wen_i    (wb_valid),
		.wb_rd_i     (wb_rd),
		.wb_data_i   (wb_data),
		.op_a_o      (op_a),
		.op_b_o      (op_b)
	);

	vi_int_alu u_int_alu (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.ex_valid_i     (ex_valid),
		.ex_op_i        (ex_op),
		.ex_is_branch_i (ex_is_branch),
		.ex_a_i         (ex_a),
		.ex_b_i         (ex_b),
		.ex_imm_i       (ex_imm),
		.ex_pc_i        (ex_pc),
		.ex_rd_i        (ex_rd),
		.ex_wen_i       (ex_wen),
		.ex_result_o    (ex_result),
		.redirect_o     (redirect),
		.redirect_pc_o  (redirect_pc),
		.wb_valid_o     (wb_valid),
		.wb_rd_o        (wb_rd),
		.wb_data_o      (wb_data)
	);

	assign retire_valid_o = wb_valid;
	assign retire_addr_o  = wb_rd;
	assign retire_data_o  = wb_data;

endmodule

/* verification/vi_tb_clock.sv */
// Clock starts low at time 0; reset is released on a rising edge after RESET_CYCLES edges
`timescale 1ns/1ns

module vi_tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

/* verification/vi_core_tb.sv */
// Fixed 48-instruction program from seed 80 at BOOT_PC; MEM_DELAY and BOOT_PC must match the DUT
`timescale 1ns/1ns

module vi_core_tb import vi_pkg::*; ();

	localparam int              MEM_DELAY      = 4;
	localparam logic [XLEN-1:0] BOOT_PC        = '0;
	localparam int              NUM_INSTR      = 48;
	localparam int              TIMEOUT_CYCLES = NUM_INSTR * (2 * MEM_DELAY + 6) + 100;
	localparam int              DRAIN_CYCLES   = 2 * (2 * MEM_DELAY + 6);
	localparam int              K_REG          = 0;
	localparam int              K_IMM          = 1;
	localparam int              K_BRANCH       = 2;

	logic                  clk_i;
	logic                  reset_i;
	logic                  mem_data_ready_i;
	logic [LINE_W-1:0]     mem_data_i;
	logic [PADDR_W-1:0]    mem_addr_i;
	logic                  mem_read_o;
	logic [PADDR_W-1:0]    mem_read_addr_o;
	logic                  retire_valid_o;
	logic [REG_ADDR_W-1:0] retire_addr_o;
	logic [XLEN-1:0]       retire_data_o;

	// Program as generated, and its encoding
	int                    prog_kind [NUM_INSTR];
	alu_op_e               prog_op   [NUM_INSTR];
	logic [REG_ADDR_W-1:0] prog_rd   [NUM_INSTR];
	logic [REG_ADDR_W-1:0] prog_rs1  [NUM_INSTR];
	logic [REG_ADDR_W-1:0] prog_rs2  [NUM_INSTR];
	logic [XLEN-1:0]       prog_imm  [NUM_INSTR];
	logic [XLEN-1:0]       prog_mem  [NUM_INSTR];

	// Register writes expected from the reference model, in order
	logic [REG_ADDR_W-1:0] exp_rd   [64];
	logic [XLEN-1:0]       exp_data [64];
	bit                    exp_dep  [64];
	int                    exp_count;
	int                    model_taken;
	int                    model_not_taken;

	logic [31:0] rng = 32'd80;
	int          cycle_count = 0;
	int          retire_idx = 0;
	int          read_count = 0;
	int          dep_checks = 0;
	logic        reset_d = 1'b1;
	logic        read_pending = 1'b0;
	logic        first_read_seen = 1'b0;
	int          reset_errors = 0;
	int          order_errors = 0;
	int          alu_errors = 0;
	int          dep_errors = 0;
	int          branch_errors = 0;
	int          total_errors;

	vi_tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(4)) u_clock (
		.clk_o   (clk_i),
		.reset_o (reset_i)
	);

	vi_core #(.MEM_DELAY(MEM_DELAY), .BOOT_PC(BOOT_PC)) u_dut (
		.clk_i            (clk_i),
		.reset_i          (reset_i),
		.mem_data_ready_i (mem_data_ready_i),
		.mem_data_i       (mem_data_i),
		.mem_addr_i       (mem_addr_i),
		.mem_read_o       (mem_read_o),
		.mem_read_addr_o  (mem_read_addr_o),
		.retire_valid_o   (retire_valid_o),
		.retire_addr_o    (retire_addr_o),
		.retire_data_o    (retire_data_o)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		rng = xorshift(rng);
		return rng % n;
	endfunction

	function automatic logic [2:0] funct3_of(input alu_op_e op);
		case (op)
			SLL, BNE: return 3'b001;
			SLT:      return 3'b010;
			XOR:      return 3'b100;
			SRL:      return 3'b101;
			OR:       return 3'b110;
			AND:      return 3'b111;
			default:  return 3'b000;
		endcase
	endfunction

	function automatic logic [31:0] encode(input int i);
		logic [31:0] imm;
		logic [2:0]  f3;
		imm = prog_imm[i];
		f3  = funct3_of(prog_op[i]);
		case (prog_kind[i])
			K_REG: return {(prog_op[i] == SUB) ? 7'h20 : 7'h00, prog_rs2[i], prog_rs1[i], f3,
				prog_rd[i], OPC_OP};
			K_IMM: return {imm[11:0], prog_rs1[i], f3, prog_rd[i], OPC_OP_IMM};
			default: return {imm[12], imm[10:5], prog_rs2[i], prog_rs1[i], f3, imm[4:1], imm[11],
				OPC_BRANCH};
		endcase
	endfunction

	// RV32I semantics of the supported ALU operations
	function automatic logic [31:0] model_alu(input alu_op_e op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			ADD:     return a + b;
			SUB:     return a - b;
			AND:     return a & b;
			OR:      return a | b;
			XOR:     return a ^ b;
			SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			SLL:     return a << b[4:0];
			SRL:     return a >> b[4:0];
			default: return '0;
		endcase
	endfunction

	task automatic build_program();
		logic [REG_ADDR_W-1:0] prev_rd;
		logic [REG_ADDR_W-1:0] rd;
		logic [11:0]           imm12;
		prev_rd = 5'd1;
		for (int i = 0; i < NUM_INSTR; i++) begin
			rd          = 5'(rand_below(8));
			prog_rd[i]  = rd;
			prog_rs1[i] = (rand_below(2) == 0) ? prev_rd : 5'(rand_below(8));
			prog_rs2[i] = (rand_below(2) == 0) ? prev_rd : 5'(rand_below(8));
			if (i == NUM_INSTR - 1) begin
				// Self-branch parks the core at the end
				prog_kind[i] = K_BRANCH;
				prog_op[i]   = BEQ;
				prog_rs1[i]  = '0;
				prog_rs2[i]  = '0;
				prog_imm[i]  = '0;
			end else if (i % 8 == 6) begin
				prog_kind[i] = K_BRANCH;
				prog_op[i]   = rand_below(2) ? BNE : BEQ;
				prog_imm[i]  = 32'(4 * (2 + rand_below(3)));
			end else begin
				prog_op[i]   = alu_op_e'(rand_below(8));
				prog_kind[i] = (rand_below(2) == 0) ? K_REG : K_IMM;
				if (prog_kind[i] == K_IMM) begin
					if (prog_op[i] == SUB)
						prog_op[i] = ADD;
					if (prog_op[i] == SLL || prog_op[i] == SRL)
						imm12 = 12'(rand_below(32));
					else
						imm12 = 12'(rand_below(4096));
					prog_imm[i] = {{20{imm12[11]}}, imm12};
				end else begin
					prog_imm[i] = '0;
				end
				if (rd != '0)
					prev_rd = rd;
			end
			prog_mem[i] = encode(i);
		end
	endtask

	task automatic run_model();
		logic [31:0]           regs [32];
		logic [31:0]           a;
		logic [31:0]           b;
		logic [REG_ADDR_W-1:0] last1;
		logic [REG_ADDR_W-1:0] last2;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		int                    idx;
		bit                    dep;
		for (int r = 0; r < 32; r++)
			regs[r] = '0;
		idx       = 0;
		last1     = '0;
		last2     = '0;
		exp_count = 0;
		while (idx < NUM_INSTR - 1) begin
			rs1 = prog_rs1[idx];
			rs2 = prog_rs2[idx];
			a   = regs[rs1];
			b   = (prog_kind[idx] == K_IMM) ? prog_imm[idx] : regs[rs2];
			if (prog_kind[idx] == K_BRANCH) begin
				if ((prog_op[idx] == BEQ) == (a == b)) begin
					model_taken++;
					idx += int'(prog_imm[idx]) / 4;
				end else begin
					model_not_taken++;
					idx++;
				end
				last2 = last1;
				last1 = '0;
			end else begin
				dep = (rs1 != '0 && (rs1 == last1 || rs1 == last2)) ||
					(prog_kind[idx] == K_REG && rs2 != '0 && (rs2 == last1 || rs2 == last2));
				if (prog_rd[idx] != '0) begin
					regs[prog_rd[idx]]  = model_alu(prog_op[idx], a, b);
					exp_rd[exp_count]   = prog_rd[idx];
					exp_data[exp_count] = regs[prog_rd[idx]];
					exp_dep[exp_count]  = dep;
					exp_count++;
				end
				last2 = last1;
				last1 = prog_rd[idx];
				idx++;
			end
		end
	endtask

	function automatic logic [LINE_W-1:0] read_line(input logic [PADDR_W-1:0] addr);
		logic [LINE_W-1:0]  line;
		logic [PADDR_W-1:0] wa;
		int                 idx;
		for (int w = 0; w < 4; w++) begin
			wa  = addr + PADDR_W'(4 * w);
			idx = int'((wa - BOOT_PC[PADDR_W-1:0]) >> 2);
			// Outside the program, opcode zero makes the word a bubble
			if (wa >= BOOT_PC[PADDR_W-1:0] && idx < NUM_INSTR)
				line[w*XLEN +: XLEN] = prog_mem[idx];
			else
				line[w*XLEN +: XLEN] = {7'h00, wa[PADDR_W-1:2], 7'h00};
		end
		return line;
	endfunction

	initial begin
		mem_data_ready_i = 1'b0;
		mem_data_i       = '0;
		mem_addr_i       = '0;
	end

	// Memory answers one cycle after each read request
	always @(posedge clk_i) begin
		if (reset_i) begin
			mem_data_ready_i <= 1'b0;
		end else if (mem_read_o) begin
			mem_data_ready_i <= 1'b1;
			mem_addr_i       <= mem_read_addr_o;
			mem_data_i       <= read_line(mem_read_addr_o);
		end else begin
			mem_data_ready_i <= 1'b0;
		end
	end

	always @(posedge clk_i) begin
		cycle_count <= cycle_count + 1;
		reset_d     <= reset_i;
		if (reset_i) begin
			read_pending    <= 1'b0;
			first_read_seen <= 1'b0;
			retire_idx      <= 0;
		end else begin
			if (mem_read_o) begin
				read_pending    <= 1'b1;
				first_read_seen <= 1'b1;
				read_count      <= read_count + 1;
			end else if (mem_data_ready_i) begin
				read_pending <= 1'b0;
			end
			if (retire_valid_o) begin
				retire_idx <= retire_idx + 1;
				if (retire_idx < exp_count && exp_dep[retire_idx])
					dep_checks <= dep_checks + 1;
			end
		end
	end

	a_reset_read: assert property (@(posedge clk_i)
		(cycle_count > 0 && (reset_i || reset_d)) |-> !mem_read_o)
	else begin
		reset_errors++;
		$display("ERROR mem_read_o in reset: got %h expected 0", $sampled(mem_read_o));
	end

	a_reset_retire: assert property (@(posedge clk_i)
		(cycle_count > 0 && (reset_i || reset_d)) |-> !retire_valid_o)
	else begin
		reset_errors++;
		$display("ERROR retire_valid_o in reset: got %h expected 0", $sampled(retire_valid_o));
	end

	a_boot_line: assert property (@(posedge clk_i) disable iff (reset_i)
		(mem_read_o && !first_read_seen) |-> mem_read_addr_o == {BOOT_PC[PADDR_W-1:4], 4'h0})
	else begin
		reset_errors++;
		$display("ERROR mem_read_addr_o: got %h expected %h", $sampled(mem_read_addr_o),
			{BOOT_PC[PADDR_W-1:4], 4'h0});
	end

	a_one_read: assert property (@(posedge clk_i) disable iff (reset_i)
		mem_read_o |-> !read_pending)
	else begin
		order_errors++;
		$display("A second memory read was issued before the previous one was answered");
	end

	a_retire_addr: assert property (@(posedge clk_i) disable iff (reset_i)
		(retire_valid_o && retire_idx < exp_count) |-> retire_addr_o == exp_rd[retire_idx])
	else begin
		alu_errors++;
		$display("ERROR retire_addr_o: got %h expected %h", $sampled(retire_addr_o),
			exp_rd[$sampled(retire_idx)]);
	end

	a_retire_data: assert property (@(posedge clk_i) disable iff (reset_i)
		(retire_valid_o && retire_idx < exp_count) |-> retire_data_o == exp_data[retire_idx])
	else begin
		alu_errors++;
		$display("ERROR retire_data_o: got %h expected %h", $sampled(retire_data_o),
			exp_data[$sampled(retire_idx)]);
	end

	// Results that needed a forwarded operand
	a_bypass_data: assert property (@(posedge clk_i) disable iff (reset_i)
		(retire_valid_o && retire_idx < exp_count && exp_dep[retire_idx])
		|-> retire_data_o == exp_data[retire_idx])
	else begin
		dep_errors++;
		$display("ERROR retire_data_o after dependence: got %h expected %h",
			$sampled(retire_data_o), exp_data[$sampled(retire_idx)]);
	end

	a_no_x0_retire: assert property (@(posedge clk_i) disable iff (reset_i)
		retire_valid_o |-> retire_addr_o != '0)
	else begin
		branch_errors++;
		$display("ERROR retire_addr_o: got %h expected nonzero", $sampled(retire_addr_o));
	end

	a_no_extra_retire: assert property (@(posedge clk_i) disable iff (reset_i)
		retire_valid_o |-> retire_idx < exp_count)
	else begin
		branch_errors++;
		$display("More register writes retired than the reference model produced");
	end

	initial begin
		build_program();
		run_model();
		while (retire_idx < exp_count && cycle_count < TIMEOUT_CYCLES)
			@(posedge clk_i);
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: %0d of %0d expected writes retired after %0d cycles",
				retire_idx, exp_count, cycle_count);
			$display("Done: errors found");
		end else begin
			// Let the self-branch spin to expose any late retire
			repeat (DRAIN_CYCLES) @(posedge clk_i);
			a_write_count: assert (retire_idx == exp_count)
			else begin
				branch_errors++;
				$display("ERROR retire_valid_o count: got %h expected %h", retire_idx, exp_count);
			end
			$display("Reset: %0d errors", reset_errors);
			$display("Memory ordering: %0d reads, %0d errors", read_count, order_errors);
			$display("ALU results: %0d writes, %0d errors", retire_idx, alu_errors);
			$display("Back-to-back dependences: %0d checked, %0d errors", dep_checks, dep_errors);
			$display("Branches: %0d taken, %0d not taken, %0d errors", model_taken,
				model_not_taken, branch_errors);
			total_errors = reset_errors + order_errors + alu_errors + dep_errors + branch_errors;
			$display("Totals: %0d cycles, %0d writes retired, %0d errors", cycle_count,
				retire_idx, total_errors);
			if (total_errors == 0)
				$display("Done: no errors");
			else
				$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* vi_core.f */
common/vi_pkg.sv
source/vi_mem_delay.sv
fetch/vi_fetch.sv
decode/vi_int_registers.sv
decode/vi_bypass_ctrl.sv
decode/vi_decoder.sv
execute/vi_int_alu.sv
source/vi_core.sv
verification/vi_tb_clock.sv
verification/vi_core_tb.sv
